// ==== verilog.f ====
common/seqmon_pkg.sv
src/frame_tracker.sv
src/seq_checker.sv
src/monitor_ctrl.sv
src/host_reg_port.sv
src/link_monitor_top.sv
verif/tb_clkgen.sv
verif/tb_link_monitor.sv

// ==== verif/tb_link_monitor.sv ====
`timescale 1ns/1ps

module tb_link_monitor;

	import seqmon_pkg::*;

	localparam int unsigned SEQ_POS    = 2;
	localparam int unsigned MAX_FRAMES = 12;
	localparam int TIMEOUT_CYCLES = 2000;  // the tests below take about 250 cycles
	localparam int ACK_LIMIT      = 8;     // cycles a read may wait on rd_ack

	logic   clk;
	logic   rst;
	logic   rx_en;
	byte_t  rx_data;
	logic   rd_req;
	addr_t  rd_addr;
	logic   rd_ack;
	count_t rd_data;
	logic   done;

	integer seed = 32'h1e16f55e;
	int     value_errors = 0;
	int     handshake_errors = 0;
	int     cycles = 0;

	// reference model of the counts
	logic   started = 1'b0;
	count_t exp_frames = '0;
	count_t exp_good = '0;
	byte_t  exp_prev = '0;

	tb_clkgen u_clkgen (
		.clk (clk),
		.rst (rst)
	);

	link_monitor_top #(
		.SEQ_POS    (SEQ_POS),
		.MAX_FRAMES (MAX_FRAMES)
	) dut0 (
		.clk     (clk),
		.rst     (rst),
		.rx_en   (rx_en),
		.rx_data (rx_data),
		.rd_req  (rd_req),
		.rd_addr (rd_addr),
		.rd_ack  (rd_ack),
		.rd_data (rd_data),
		.done    (done)
	);

	initial begin
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("** FAIL **");
		$finish;
	end

	// ------------------------------------------------------------------------
	// compare tasks
	// ------------------------------------------------------------------------

	task automatic check_count(input string name, input count_t exp, input count_t act);
		if (act !== exp) begin
			value_errors++;
			$display("CHECK FAILED %s: expected 0x%08h, got 0x%08h", name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			value_errors++;
			$display("CHECK FAILED %s: expected 0x%0h, got 0x%0h", name, exp, act);
		end
	endtask

	// status word holds done in bit 0 and the state in bits 2:1
	task automatic check_status(input mon_state_t exp_state, input logic exp_done,
			input count_t act);
		count_t exp;
		exp = '0;
		exp[0] = exp_done;
		exp[2:1] = exp_state;
		if (act !== exp) begin
			value_errors++;
			$display("CHECK FAILED status: expected 0x%08h, got 0x%08h", exp, act);
		end
	endtask

	// ------------------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------------------

	task automatic update_model(input byte_t seq, input int len);
		if (len > int'(SEQ_POS)) begin  // runts never count
			if (!started) begin
				if (seq == 8'd0) begin
					started = 1'b1;
					exp_frames = 1;
					exp_good = 1;
					exp_prev = seq;
				end
			end else if (exp_frames < MAX_FRAMES) begin
				exp_frames++;
				if (seq == byte_t'(exp_prev + 8'd1))
					exp_good++;
				exp_prev = seq;
			end
		end
	endtask

	function automatic mon_state_t expected_state();
		if (!started)
			return MON_WAIT_START;
		else if (exp_frames == MAX_FRAMES)
			return MON_DONE;
		else
			return MON_RUNNING;
	endfunction

	// ------------------------------------------------------------------------
	// bus tasks
	// ------------------------------------------------------------------------

	// random filler around the sequence byte at SEQ_POS and 3 idle cycles after
	task automatic send_frame(input byte_t seq, input int len);
		int i;
		int rnd;
		for (i = 0; i < len; i++) begin
			@(posedge clk);
			#10;
			rnd = $random(seed);
			rx_en = 1'b1;
			rx_data = (i == int'(SEQ_POS)) ? seq : rnd[7:0];
		end
		repeat (3) begin
			@(posedge clk);
			#10;
			rx_en = 1'b0;
			rx_data = '0;
		end
		update_model(seq, len);
	endtask

	task automatic host_read(input addr_t addr, output count_t data);
		int waited;
		waited = 0;
		data = '0;
		@(posedge clk);
		#10;
		rd_addr = addr;
		rd_req = 1'b1;
		while (rd_ack !== 1'b1 && waited < ACK_LIMIT) begin
			@(posedge clk);
			#10;
			waited++;
		end
		if (rd_ack !== 1'b1) begin
			handshake_errors++;
			$display("read of address %0d got no rd_ack within %0d cycles", addr, ACK_LIMIT);
		end else begin
			data = rd_data;
		end
		rd_req = 1'b0;
		waited = 0;
		while (rd_ack !== 1'b0 && waited < ACK_LIMIT) begin
			@(posedge clk);
			#10;
			waited++;
		end
		if (rd_ack !== 1'b0) begin
			handshake_errors++;
			$display("rd_ack stayed high after the read request was dropped");
		end
	endtask

	task automatic verify_counts();
		count_t word;
		host_read(ADDR_FRAMES, word);
		check_count("frame_count", exp_frames, word);
		host_read(ADDR_GOOD, word);
		check_count("good_count", exp_good, word);
		host_read(ADDR_STATUS, word);
		check_status(expected_state(), started && (exp_frames == MAX_FRAMES), word);
	endtask

	// ------------------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------------------

	initial begin
		count_t word;
		rx_en = 1'b0;
		rx_data = '0;
		rd_req = 1'b0;
		rd_addr = ADDR_FRAMES;
		wait (rst === 1'b0);
		@(posedge clk);
		#10;

		// idle after reset
		check_flag("done", 1'b0, done);
		check_flag("rd_ack", 1'b0, rd_ack);
		verify_counts();
		host_read(addr_t'(3), word);
		check_count("rd_data unmapped", '0, word);

		// nonzero frames before the start are ignored
		send_frame(8'd5, 5);
		send_frame(8'd7, 4);
		verify_counts();
		send_frame(8'd0, 4);
		send_frame(8'd1, 5);
		send_frame(8'd2, 3);
		send_frame(8'd3, 6);
		verify_counts();

		// skip, repeat, then resync
		send_frame(8'd5, 4);
		send_frame(8'd5, 5);
		verify_counts();
		send_frame(8'd6, 4);
		verify_counts();

		// runts against a minimum length frame
		send_frame(8'd9, 2);
		send_frame(8'd9, 2);
		verify_counts();
		send_frame(8'd7, 3);
		verify_counts();

		// wrap through 255
		send_frame(8'd254, 4);
		send_frame(8'd255, 5);
		send_frame(8'd0, 4);
		verify_counts();

		// twelfth frame ends the run
		send_frame(8'd1, 5);
		check_flag("done", 1'b1, done);
		verify_counts();
		fork
			send_frame(8'd2, 8);
			begin
				// first read mid-frame, second one after the frame has ended
				repeat (6) @(posedge clk);
				host_read(ADDR_FRAMES, word);
				check_count("frame_count", exp_frames, word);
				host_read(ADDR_GOOD, word);
				check_count("good_count", exp_good, word);
			end
		join
		send_frame(8'd3, 4);
		check_flag("done", 1'b1, done);
		verify_counts();

		$display("errors: %0d value mismatches, %0d handshake failures",
			value_errors, handshake_errors);
		if (value_errors + handshake_errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// ==== verif/tb_clkgen.sv ====
`timescale 1ns/1ps

module tb_clkgen #(
	parameter int PERIOD_NS    = 100,
	parameter int RESET_CYCLES = 8,
	parameter int DRIVE_DELAY  = 10   // same offset the stimulus uses
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// reset released just after an edge, like every other input
	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#(DRIVE_DELAY);
		rst = 1'b0;
	end

endmodule

// ==== src/link_monitor_top.sv ====
`timescale 1ns/1ps

module link_monitor_top #(
	parameter int unsigned SEQ_POS    = 0,
	parameter int unsigned MAX_FRAMES = 100000
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               rx_en,
	input  seqmon_pkg::byte_t  rx_data,
	input  logic               rd_req,
	input  seqmon_pkg::addr_t  rd_addr,
	output logic               rd_ack,
	output seqmon_pkg::count_t rd_data,
	output logic               done
);

	import seqmon_pkg::*;

	// ------------------------------------------------------------------------
	// internal nets
	// ------------------------------------------------------------------------

	logic       frame_done;
	byte_t      frame_seq;
	logic       start_frame;
	logic       count_frame;
	count_t     frame_count;
	count_t     good_count;
	mon_state_t state;

	// byte stream -> completed frames
	frame_tracker #(
		.SEQ_POS     (SEQ_POS)
	) u_frame_tracker (
		.clk         (clk),
		.rst         (rst),
		.rx_en       (rx_en),
		.rx_data     (rx_data),
		.frame_done  (frame_done),
		.frame_seq   (frame_seq)
	);

	// decides which frames count
	monitor_ctrl #(
		.MAX_FRAMES  (MAX_FRAMES)
	) u_monitor_ctrl (
		.clk         (clk),
		.rst         (rst),
		.frame_done  (frame_done),
		.frame_seq   (frame_seq),
		.frame_count (frame_count),
		.start_frame (start_frame),
		.count_frame (count_frame),
		.state       (state),
		.done        (done)
	);

	seq_checker u_seq_checker (
		.clk         (clk),
		.rst         (rst),
		.frame_seq   (frame_seq),
		.start_frame (start_frame),
		.count_frame (count_frame),
		.frame_count (frame_count),
		.good_count  (good_count)
	);

	// host side
	host_reg_port u_host_reg_port (
		.clk         (clk),
		.rst         (rst),
		.rd_req      (rd_req),
		.rd_addr     (rd_addr),
		.rd_ack      (rd_ack),
		.rd_data     (rd_data),
		.frame_count (frame_count),
		.good_count  (good_count),
		.state       (state),
		.done        (done)
	);

endmodule

// ==== src/host_reg_port.sv ====
`timescale 1ns/1ps

module host_reg_port (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   rd_req,
	input  seqmon_pkg::addr_t      rd_addr,
	output logic                   rd_ack,
	output seqmon_pkg::count_t     rd_data,
	input  seqmon_pkg::count_t     frame_count,
	input  seqmon_pkg::count_t     good_count,
	input  seqmon_pkg::mon_state_t state,
	input  logic                   done
);

	import seqmon_pkg::*;

	count_t status_word;
	count_t rd_word;     // word picked by rd_addr
	logic   rd_start;    // new request seen this cycle

	// ------------------------------------------------------------------------
	// register select
	// ------------------------------------------------------------------------

	always_comb begin
		status_word = '0;
		status_word[STATUS_DONE_BIT] = done;
		status_word[STATUS_STATE_LO +: 2] = state;
	end

	always_comb begin
		case (rd_addr)
			ADDR_FRAMES: rd_word = frame_count;
			ADDR_GOOD:   rd_word = good_count;
			ADDR_STATUS: rd_word = status_word;
			default:     rd_word = '0;  // unmapped
		endcase
	end

	// ------------------------------------------------------------------------
	// four-phase handshake
	// ------------------------------------------------------------------------

	assign rd_start = rd_req && !rd_ack;

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_ack <= 1'b0;
		end else if (rd_start) begin
			rd_ack <= 1'b1;
		end else if (!rd_req) begin
			rd_ack <= 1'b0;  // host released, close the cycle
		end
	end

	// snapshot at ack time, stays put while rd_ack is high
	always_ff @(posedge clk) begin
		if (rd_start)
			rd_data <= rd_word;
	end

endmodule

// ==== src/monitor_ctrl.sv ====
`timescale 1ns/1ps

module monitor_ctrl #(
	parameter int unsigned MAX_FRAMES = 100000
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   frame_done,
	input  seqmon_pkg::byte_t      frame_seq,
	input  seqmon_pkg::count_t     frame_count,
	output logic                   start_frame,
	output logic                   count_frame,
	output seqmon_pkg::mon_state_t state,
	output logic                   done
);

	import seqmon_pkg::*;

	mon_state_t state_next;
	logic       at_max;
	logic       seq_zero;

	assign at_max   = (frame_count == count_t'(MAX_FRAMES));
	assign seq_zero = (frame_seq == '0);

	// ------------------------------------------------------------------------
	// strobes to the checker
	// ------------------------------------------------------------------------

	// first complete frame numbered zero opens the run
	assign start_frame = frame_done && (state == MON_WAIT_START) && seq_zero;

	// every complete frame while running
	assign count_frame = frame_done && (state == MON_RUNNING);

	// ------------------------------------------------------------------------
	// state machine
	// ------------------------------------------------------------------------

	always_comb begin
		state_next = state;
		case (state)
			MON_INIT: begin
				state_next = MON_WAIT_START;
			end
			MON_WAIT_START: begin
				if (start_frame)
					state_next = MON_RUNNING;
			end
			MON_RUNNING: begin
				if (at_max)
					state_next = MON_DONE;  // counts freeze from here
			end
			default: begin
				state_next = MON_DONE;  // left only by reset
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			state <= MON_INIT;
		else
			state <= state_next;
	end

	assign done = (state == MON_DONE);

endmodule

// ==== src/seq_checker.sv ====
`timescale 1ns/1ps

module seq_checker (
	input  logic               clk,
	input  logic               rst,
	input  seqmon_pkg::byte_t  frame_seq,
	input  logic               start_frame,
	input  logic               count_frame,
	output seqmon_pkg::count_t frame_count,
	output seqmon_pkg::count_t good_count
);

	import seqmon_pkg::*;

	byte_t prev_seq;   // number of the last counted frame
	byte_t next_seq;   // what a good frame should carry
	logic  seq_ok;

	assign next_seq = byte_t'(prev_seq + 8'd1);  // wraps 255 -> 0
	assign seq_ok   = (frame_seq == next_seq);

	// ------------------------------------------------------------------------
	// previous number
	// ------------------------------------------------------------------------

	// always follows the received value, so one bad number
	// costs a single good frame and the check locks on again
	always_ff @(posedge clk) begin
		if (rst) begin
			prev_seq <= '0;
		end else if (start_frame || count_frame) begin
			prev_seq <= frame_seq;
		end
	end

	// ------------------------------------------------------------------------
	// counters
	// ------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			frame_count <= '0;
		end else if (start_frame) begin
			frame_count <= count_t'(1);  // start frame counts itself
		end else if (count_frame) begin
			frame_count <= frame_count + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			good_count <= '0;
		end else if (start_frame) begin
			good_count <= count_t'(1);
		end else if (count_frame && seq_ok) begin
			good_count <= good_count + 1'b1;
		end
	end

endmodule

// ==== src/frame_tracker.sv ====
`timescale 1ns/1ps

module frame_tracker #(
	parameter int unsigned SEQ_POS = 0
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               rx_en,
	input  seqmon_pkg::byte_t  rx_data,
	output logic               frame_done,
	output seqmon_pkg::byte_t  frame_seq
);

	import seqmon_pkg::*;

	pos_t pos;       // index of the byte currently on rx_data
	logic seq_seen;  // sequence byte captured in this frame
	logic at_seq;

	assign at_seq = rx_en && (pos == pos_t'(SEQ_POS));

	// ------------------------------------------------------------------------
	// byte position, back to zero in every idle cycle
	// ------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			pos <= '0;
		end else if (!rx_en) begin
			pos <= '0;
		end else if (pos != POS_MAX) begin
			pos <= pos + 1'b1;  // saturate on huge frames
		end
	end

	// frame is reportable once the sequence byte went by
	always_ff @(posedge clk) begin
		if (rst) begin
			seq_seen <= 1'b0;
		end else if (!rx_en) begin
			seq_seen <= 1'b0;
		end else if (at_seq) begin
			seq_seen <= 1'b1;
		end
	end

	// sequence byte, held until the next frame overwrites it
	always_ff @(posedge clk) begin
		if (at_seq) begin
			frame_seq <= rx_data;
		end
	end

	// first idle cycle after a long enough frame, runts never get here
	assign frame_done = !rx_en && seq_seen;

endmodule

// ==== common/seqmon_pkg.sv ====
package seqmon_pkg;

	// ------------------------------------------------------------------------
	// data widths
	// ------------------------------------------------------------------------

	typedef logic [7:0]  byte_t;   // rx byte, also the sequence number
	typedef logic [31:0] count_t;  // frame and good counters
	typedef logic [1:0]  addr_t;   // host read address
	typedef logic [15:0] pos_t;    // byte index inside a frame

	// top of the position counter, it parks here on very long frames
	localparam pos_t POS_MAX = '1;

	// ------------------------------------------------------------------------
	// controller states
	// ------------------------------------------------------------------------

	typedef enum logic [1:0] {
		MON_INIT       = 2'd0,
		MON_WAIT_START = 2'd1,
		MON_RUNNING    = 2'd2,
		MON_DONE       = 2'd3
	} mon_state_t;

	// ------------------------------------------------------------------------
	// read port address map
	// ------------------------------------------------------------------------

	localparam addr_t ADDR_FRAMES = 2'd0;  // frame_count
	localparam addr_t ADDR_GOOD   = 2'd1;  // good_count
	localparam addr_t ADDR_STATUS = 2'd2;  // {state, done}

	// status word packing, upper bits read as zero
	localparam int STATUS_DONE_BIT = 0;
	localparam int STATUS_STATE_LO = 1;

endpackage
